// ==== Makefile ====
# Verilator build and run for the hss frame tx block

VERILATOR ?= verilator
TOP       ?= hss_frame_tx_tb
DUT_TOP   ?= hss_frame_tx_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "all tests passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only --top-module $(DUT_TOP) +incdir+. \
		hss_pkt_pkg.sv hss_frm_pkg.sv hss_pkt_arbiter.sv hss_retx_buffer.sv \
		hss_frame_assembler.sv hss_frame_tx_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hss_frame_assembler.sv ====
// hss frame assembler: FSM turning new or replayed packets into 2 or 3 word frames
`default_nettype none
`timescale 1ns/100ps

`include "hss_mux_config.svh"

module hss_frame_assembler
  import hss_pkt_pkg::*;
  import hss_frm_pkg::*;
(
  input  wire               tbr_clk,
  input  wire               tbr_rst,

  // from arbiter
  input  wire               grant_vld,
  input  wire hss_chan_t    grant_chan,
  input  wire hss_pkt_t     grant_pkt,

  // from retransmit buffer
  input  wire hss_seq_t     next_seq,
  input  wire               replay_vld,
  input  wire hss_seq_t     replay_seq,
  input  wire hss_chan_t    replay_chan,
  input  wire hss_pkt_t     replay_pkt,
  input  wire               credit_ok,

  // requests and start strobes
  output logic              asm_take,
  output logic              new_start,
  output hss_pkt_t          new_pkt,
  output hss_chan_t         new_chan,
  output logic              replay_start,

  // frame output
  output hss_frm_word_t     frm_data,
  output hss_kbits_t        frm_kchr,
  output logic              frm_last,
  output logic              frm_vld,
  input  wire               frm_rdy,

  output logic              reg_sfrm
);

  hss_asm_state_e state;
  hss_asm_state_e state_nxt;

  // frame being sent
  hss_pkt_t       cur_pkt;
  hss_seq_t       cur_seq;
  hss_chan_t      cur_chan;
  hss_hdr_t       cur_hdr;
  logic           has_pld;
  logic           idle;

  // ------------------------------------------------------------
  // frame start
  // ------------------------------------------------------------
  assign idle = (state == ASM_IDLE);

  // replay first, new packets need credit
  assign replay_start = idle && replay_vld;
  assign asm_take     = idle && credit_ok && !replay_vld;
  assign new_start    = asm_take && grant_vld;
  assign new_pkt      = grant_pkt;
  assign new_chan     = grant_chan;

  always_ff @(posedge tbr_clk)
    if (replay_start)
    begin
      cur_pkt  <= replay_pkt;
      cur_seq  <= replay_seq;
      cur_chan <= replay_chan;
    end
    else if (new_start)
    begin
      cur_pkt  <= grant_pkt;
      cur_seq  <= next_seq;
      cur_chan <= grant_chan;
    end

  assign cur_hdr = cur_pkt[HSS_PKT_HDR_LSB +: $bits(hss_hdr_t)];
  assign has_pld = cur_hdr[HSS_HDR_PLD_BIT];

  // ------------------------------------------------------------
  // FSM, word advance only on frm_rdy
  // ------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      ASM_IDLE: if (replay_start || new_start) state_nxt = ASM_HDR;
      ASM_HDR:  if (frm_rdy) state_nxt = ASM_KEY;
      ASM_KEY:  if (frm_rdy) state_nxt = has_pld ? ASM_PLD : ASM_IDLE;
      ASM_PLD:  if (frm_rdy) state_nxt = ASM_IDLE;
      default:  state_nxt = ASM_IDLE;
    endcase
  end

  always_ff @(posedge tbr_clk or posedge tbr_rst)
    if (tbr_rst)
      state <= ASM_IDLE;
    else
      state <= state_nxt;

  // ------------------------------------------------------------
  // word build
  // ------------------------------------------------------------
  always_comb
  begin
    frm_data = '0;
    frm_kchr = '0;
    case (state)
      ASM_HDR:
      begin
        frm_data[HSS_FRM_KCHR_LSB +: 8]                  = `HSS_KCHAR;
        frm_data[HSS_FRM_HDR_LSB +: $bits(hss_hdr_t)]    = cur_hdr;
        frm_data[HSS_FRM_CHAN_LSB +: $bits(hss_chan_t)]  = cur_chan;
        frm_data[HSS_FRM_SEQ_LSB +: $bits(hss_seq_t)]    = cur_seq;
        frm_kchr                                         = `HSS_DATA_KBITS;
      end
      ASM_KEY: frm_data = cur_pkt[HSS_PKT_KEY_LSB +: $bits(hss_frm_word_t)];
      ASM_PLD: frm_data = cur_pkt[HSS_PKT_PLD_LSB +: $bits(hss_frm_word_t)];
      default: frm_data = '0;
    endcase
  end

  assign frm_vld  = !idle;
  // key ends a frame without payload
  assign frm_last = ((state == ASM_KEY) && !has_pld) || (state == ASM_PLD);
  assign reg_sfrm = frm_vld && frm_rdy && frm_last;

endmodule

`default_nettype wire

// ==== hss_frame_tx_tb.sv ====
// hss frame tx testbench with channel senders, ack/nak responder, reference frames and checks
`default_nettype none
`timescale 1ns/100ps

`include "hss_mux_config.svh"

module hss_frame_tx_tb
  import hss_pkt_pkg::*;
  import hss_frm_pkg::*;
;
  localparam int NCH = `HSS_NUM_CHANS;
  localparam int TMO = 3000;

  logic tbr_clk, tbr_rst;
  hss_pkt_t [NCH-1:0] pkt_data;
  logic [NCH-1:0] pkt_vld, pkt_rdy, cfc_rem;
  hss_ack_e ack_type;
  logic [`HSS_CLR_BITS-1:0] ack_colour;
  hss_seq_t ack_seq;
  logic ack_vld, frm_rdy;
  hss_frm_word_t frm_data;
  hss_kbits_t frm_kchr;
  logic frm_last, frm_vld, ooc_vld;
  logic [`HSS_CLR_BITS-1:0] ooc_colour;
  logic reg_sfrm, reg_rnak, reg_rack, reg_looc, reg_empt, reg_full;

  hss_frame_tx_top dut_i (.*);

  // ------------------------------------------------------------
  // scoreboard state
  // ------------------------------------------------------------
  hss_pkt_t pend_q [NCH][$];
  hss_pkt_t offer_q [NCH][$];
  hss_frm_word_t cap_w [$];
  hss_kbits_t cap_k [$];
  bit cap_l [$];
  hss_seq_t rep_q [$];
  hss_chan_t chan_log [$];
  // window mirror by low seq bits
  hss_pkt_t win_pkt [`HSS_WINDOW];
  hss_chan_t win_chan [`HSS_WINDOW];
  hss_seq_t nseq;
  logic [`HSS_CLR_BITS-1:0] colour_m;
  logic [NCH-1:0] took_r, cfc_mask;
  int frames_done, acked_frames, err_cnt, pass_cnt, fail_cnt;
  int sfrm_cnt, looc_cnt, rack_cnt, rnak_cnt;
  bit running, auto_ack, rand_rdy, req_pend;
  hss_ack_e req_type;
  logic [`HSS_CLR_BITS-1:0] req_col;
  hss_seq_t req_seq;
  // held word while frm_rdy low
  bit hold_v, hold_l;
  hss_frm_word_t hold_w;
  hss_kbits_t hold_k;

  initial
  begin
    tbr_clk = 1'b0;
    forever #5 tbr_clk = ~tbr_clk;
  end

  // ------------------------------------------------------------
  // reference model and compare tasks
  // ------------------------------------------------------------
  // expected words of one frame straight from the header layout
  function automatic void frame_words(input hss_pkt_t pkt, input hss_chan_t ch,
    input hss_seq_t sq, output hss_frm_word_t w [3], output hss_kbits_t k [3],
    output bit l [3], output int n);
    w[0] = '0;
    w[0][7:0] = `HSS_KCHAR;
    w[0][15:8] = pkt[7:0];
    w[0][18:16] = ch;
    w[0][27:24] = sq;
    w[1] = pkt[39:8];
    w[2] = pkt[71:40];
    k[0] = `HSS_DATA_KBITS;
    k[1] = '0;
    k[2] = '0;
    // payload flag in header bit 1
    n = pkt[1] ? 3 : 2;
    l[0] = 1'b0;
    l[1] = (n == 2);
    l[2] = 1'b1;
  endfunction

  task automatic check_word(input hss_frm_word_t gw, input hss_kbits_t gk, input bit gl,
    input hss_frm_word_t ew, input hss_kbits_t ek, input bit el);
    if (gw !== ew || gk !== ek || gl !== el)
    begin
      err_cnt++;
      $display("error @%0t: word %h k %h last %0b, expected %h k %h last %0b",
        $time, gw, gk, gl, ew, ek, el);
    end
  endtask

  task automatic check_seq(input hss_seq_t got, input hss_seq_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("error @%0t: seq %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_chan(input hss_chan_t got, input hss_chan_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("error @%0t: channel %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("error @%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
    begin
      err_cnt++;
      $display("error @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic bit frame_ready();
    foreach (cap_l[i])
      if (cap_l[i])
        return 1'b1;
    return 1'b0;
  endfunction

  // pop complete frames off the capture queue and check them
  task automatic process_frames();
    hss_frm_word_t ew [3];
    hss_kbits_t ek [3];
    bit el [3];
    int en;
    hss_chan_t ch;
    hss_seq_t sq;
    hss_pkt_t pkt;
    while (frame_ready())
    begin
      ch = cap_w[0][18:16];
      sq = nseq;
      if (rep_q.size() > 0)
      begin
        // replayed frame taken from the window mirror
        sq = rep_q.pop_front();
        pkt = win_pkt[sq[2:0]];
        ch = win_chan[sq[2:0]];
      end
      else if (offer_q[ch].size() == 0)
      begin
        err_cnt++;
        $display("error @%0t: frame on channel %0d with nothing offered", $time, ch);
        pkt = '0;
      end
      else
      begin
        pkt = offer_q[ch].pop_front();
        win_pkt[sq[2:0]] = pkt;
        win_chan[sq[2:0]] = ch;
        nseq = nseq + 1'b1;
      end
      check_seq(cap_w[0][27:24], sq);
      chan_log.push_back(ch);
      frame_words(pkt, ch, sq, ew, ek, el, en);
      for (int i = 0; i < en; i++)
        if (cap_w.size() > 0)
          check_word(cap_w.pop_front(), cap_k.pop_front(), cap_l.pop_front(),
            ew[i], ek[i], el[i]);
      frames_done++;
    end
  endtask

  // ------------------------------------------------------------
  // monitor sampling on the rising edge
  // ------------------------------------------------------------
  always @(posedge tbr_clk)
    if (running)
    begin
      took_r = pkt_vld & pkt_rdy;
      if (hold_v && (!frm_vld || frm_data !== hold_w || frm_kchr !== hold_k ||
          frm_last !== hold_l))
      begin
        err_cnt++;
        $display("error @%0t: frame word changed while frm_rdy low", $time);
      end
      hold_v = frm_vld && !frm_rdy;
      hold_w = frm_data;
      hold_k = frm_kchr;
      hold_l = frm_last;
      if (frm_vld && frm_rdy)
      begin
        cap_w.push_back(frm_data);
        cap_k.push_back(frm_kchr);
        cap_l.push_back(frm_last);
      end
      sfrm_cnt += int'(reg_sfrm);
      looc_cnt += int'(reg_looc);
      rack_cnt += int'(reg_rack);
      rnak_cnt += int'(reg_rnak);
    end

  // compare first and then drive answers, channels and frm_rdy on the falling edge
  always @(negedge tbr_clk)
    if (running)
    begin
      process_frames();
      ack_vld = 1'b0;
      if (req_pend)
      begin
        ack_type = req_type;
        ack_colour = req_col;
        ack_seq = req_seq;
        ack_vld = 1'b1;
        req_pend = 1'b0;
      end
      else if (auto_ack && frames_done != acked_frames && rep_q.size() == 0)
      begin
        // acks everything compared so far
        ack_type = HSS_ACK;
        ack_colour = colour_m;
        ack_seq = nseq;
        ack_vld = 1'b1;
        acked_frames = frames_done;
      end
      for (int c = 0; c < NCH; c++)
      begin
        if (took_r[c])
          pkt_vld[c] = 1'b0;
        if (!pkt_vld[c] && pend_q[c].size() > 0)
        begin
          pkt_data[c] = pend_q[c].pop_front();
          pkt_vld[c] = 1'b1;
          offer_q[c].push_back(pkt_data[c]);
        end
      end
      took_r = '0;
      cfc_rem = cfc_mask;
      frm_rdy = rand_rdy ? 1'($urandom % 2) : 1'b1;
    end

  // ------------------------------------------------------------
  // test helpers
  // ------------------------------------------------------------
  task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  task automatic offer(input int ch, input int n);
    hss_pkt_t p;
    for (int i = 0; i < n; i++)
    begin
      p = {$urandom, $urandom, 6'($urandom), 1'($urandom), 1'b0};
      p[0] = ^p[7:1];
      pend_q[ch].push_back(p);
    end
  endtask

  task automatic wait_frames(input int target);
    int t = 0;
    while (frames_done < target)
    begin
      @(posedge tbr_clk);
      if (++t > TMO)
        timed_out("frames");
    end
  endtask

  task automatic send_answer(input hss_ack_e kind, input logic col, input hss_seq_t sq);
    int t = 0;
    @(posedge tbr_clk);
    req_type = kind;
    req_col = col;
    req_seq = sq;
    req_pend = 1'b1;
    while (req_pend)
    begin
      @(posedge tbr_clk);
      if (++t > TMO)
        timed_out("ack/nak drive");
    end
  endtask

  // all offered packets framed and acked
  task automatic settle();
    int t = 0;
    int busy = 1;
    while (busy)
    begin
      @(posedge tbr_clk);
      busy = !reg_empt || frm_vld || rep_q.size() > 0;
      for (int c = 0; c < NCH; c++)
        if (pend_q[c].size() > 0 || offer_q[c].size() > 0)
          busy = 1;
      if (++t > TMO)
        timed_out("idle window");
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge tbr_clk);
  endtask

  task automatic report(input string name, input int e0);
    if (err_cnt == e0)
    begin
      pass_cnt++;
      $display("test %s: ok", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: FAILED with %0d errors", name, err_cnt - e0);
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial
  begin
    int e0, f0, s0, l0, r0, n0;
    hss_seq_t s;
    void'($urandom(32'hb779_1e3c));
    tbr_rst = 1'b1;
    pkt_data = '0;
    pkt_vld = '0;
    cfc_rem = '1;
    cfc_mask = '1;
    ack_type = HSS_ACK;
    ack_colour = '0;
    ack_seq = '0;
    ack_vld = 1'b0;
    frm_rdy = 1'b1;
    nseq = '0;
    colour_m = '0;
    auto_ack = 1'b1;
    repeat (16) @(negedge tbr_clk);
    tbr_rst = 1'b0;
    e0 = err_cnt;
    check_bit("frm_vld", frm_vld, 1'b0);
    check_bit("pkt_rdy", |pkt_rdy, 1'b0);
    check_bit("ooc_vld", ooc_vld, 1'b0);
    check_bit("reg_sfrm", reg_sfrm, 1'b0);
    check_bit("reg_rnak", reg_rnak, 1'b0);
    check_bit("reg_rack", reg_rack, 1'b0);
    check_bit("reg_looc", reg_looc, 1'b0);
    check_bit("reg_full", reg_full, 1'b0);
    check_bit("reg_empt", reg_empt, 1'b1);
    running = 1'b1;
    report("reset", e0);

    // single channel stream
    e0 = err_cnt;
    f0 = frames_done;
    s0 = sfrm_cnt;
    offer(0, 20);
    wait_frames(f0 + 20);
    settle();
    check_count("reg_sfrm pulses", sfrm_cnt - s0, 20);
    report("single channel", e0);

    // all channels in strict round robin
    e0 = err_cnt;
    f0 = frames_done;
    n0 = chan_log.size();
    for (int c = 0; c < NCH; c++)
      offer(c, 2);
    wait_frames(f0 + 2 * NCH);
    for (int i = n0 + 1; i < chan_log.size(); i++)
      check_chan(chan_log[i], hss_chan_t'(chan_log[i-1] + 1'b1));
    settle();
    report("round robin", e0);

    // flow control mask on channels 2 and 3
    e0 = err_cnt;
    f0 = frames_done;
    n0 = chan_log.size();
    cfc_mask = 8'hF3;
    for (int c = 0; c < NCH; c++)
      offer(c, 2);
    wait_frames(f0 + 12);
    idle_cycles(30);
    check_count("frames sent", frames_done - f0, 12);
    for (int i = n0; i < chan_log.size(); i++)
      check_bit("masked channel seen", chan_log[i] == 2 || chan_log[i] == 3, 1'b0);
    cfc_mask = '1;
    wait_frames(f0 + 16);
    settle();
    report("flow control", e0);

    // acks withheld until the window fills
    e0 = err_cnt;
    f0 = frames_done;
    l0 = looc_cnt;
    auto_ack = 1'b0;
    offer(0, 12);
    wait_frames(f0 + 8);
    idle_cycles(30);
    check_count("frames sent", frames_done - f0, 8);
    check_bit("reg_full", reg_full, 1'b1);
    check_bit("ooc_vld", ooc_vld, 1'b1);
    check_bit("ooc_colour", ooc_colour, 1'b0);
    check_count("reg_looc pulses", looc_cnt - l0, 1);
    send_answer(HSS_ACK, colour_m, nseq);
    @(negedge tbr_clk);
    check_bit("reg_empt", reg_empt, 1'b1);
    check_bit("reg_full", reg_full, 1'b0);
    check_bit("reg_rack", reg_rack, 1'b1);
    auto_ack = 1'b1;
    wait_frames(f0 + 12);
    settle();
    report("window full", e0);

    // nak and stale ack
    e0 = err_cnt;
    f0 = frames_done;
    r0 = rnak_cnt;
    auto_ack = 1'b0;
    offer(1, 5);
    wait_frames(f0 + 5);
    s = nseq - 3'd3;
    for (int i = 0; i < 3; i++)
      rep_q.push_back(s + hss_seq_t'(i));
    send_answer(HSS_NAK, colour_m, s);
    colour_m = ~colour_m;
    wait_frames(f0 + 8);
    check_count("reg_rnak pulses", rnak_cnt - r0, 1);
    check_bit("ooc_colour", ooc_colour, colour_m);
    r0 = rack_cnt;
    send_answer(HSS_ACK, ~colour_m, nseq);
    idle_cycles(4);
    check_count("stale reg_rack pulses", rack_cnt - r0, 0);
    check_bit("reg_empt", reg_empt, 1'b0);
    auto_ack = 1'b1;
    settle();
    report("nak replay", e0);

    // random frame back-pressure
    e0 = err_cnt;
    f0 = frames_done;
    rand_rdy = 1'b1;
    for (int i = 0; i < 24; i++)
      offer(int'($urandom % NCH), 1);
    wait_frames(f0 + 24);
    rand_rdy = 1'b0;
    settle();
    report("back-pressure", e0);

    $display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hss_frame_tx_top.sv ====
// hss frame tx top: arbiter, retransmit buffer and frame assembler on one clock
`default_nettype none
`timescale 1ns/100ps

`include "hss_mux_config.svh"

module hss_frame_tx_top
  import hss_pkt_pkg::*;
  import hss_frm_pkg::*;
(
  input  wire                              tbr_clk,
  input  wire                              tbr_rst,

  // packet channels
  input  wire hss_pkt_t [`HSS_NUM_CHANS-1:0] pkt_data,
  input  wire       [`HSS_NUM_CHANS-1:0]   pkt_vld,
  output wire       [`HSS_NUM_CHANS-1:0]   pkt_rdy,
  input  wire       [`HSS_NUM_CHANS-1:0]   cfc_rem,

  // ack/nak
  input  wire hss_ack_e                    ack_type,
  input  wire [`HSS_CLR_BITS-1:0]          ack_colour,
  input  wire hss_seq_t                    ack_seq,
  input  wire                              ack_vld,

  // frames
  output wire hss_frm_word_t               frm_data,
  output wire hss_kbits_t                  frm_kchr,
  output wire                              frm_last,
  output wire                              frm_vld,
  input  wire                              frm_rdy,

  // out-of-credit
  output wire                              ooc_vld,
  output wire [`HSS_CLR_BITS-1:0]          ooc_colour,

  // status
  output wire                              reg_sfrm,
  output wire                              reg_rnak,
  output wire                              reg_rack,
  output wire                              reg_looc,
  output wire                              reg_empt,
  output wire                              reg_full
);

  // ------------------------------------------------------------
  // internal connections
  // ------------------------------------------------------------
  wire            asm_take;
  wire            grant_vld;
  wire hss_chan_t grant_chan;
  wire hss_pkt_t  grant_pkt;
  wire            new_start;
  wire hss_pkt_t  new_pkt;
  wire hss_chan_t new_chan;
  wire            replay_start;
  wire hss_seq_t  next_seq;
  wire            replay_vld;
  wire hss_seq_t  replay_seq;
  wire hss_chan_t replay_chan;
  wire hss_pkt_t  replay_pkt;
  wire            credit_ok;

  // channel pick
  hss_pkt_arbiter arb_i (
    .tbr_clk, .tbr_rst, .pkt_data, .pkt_vld, .pkt_rdy, .cfc_rem,
    .asm_take, .grant_vld, .grant_chan, .grant_pkt
  );

  // window, ack/nak and replay
  hss_retx_buffer buf_i (
    .tbr_clk, .tbr_rst, .new_start, .new_pkt, .new_chan, .replay_start,
    .ack_type, .ack_colour, .ack_seq, .ack_vld,
    .next_seq, .replay_vld, .replay_seq, .replay_chan, .replay_pkt, .credit_ok,
    .ooc_vld, .ooc_colour, .reg_rack, .reg_rnak, .reg_looc, .reg_empt, .reg_full
  );

  // framing
  hss_frame_assembler asm_i (
    .tbr_clk, .tbr_rst, .grant_vld, .grant_chan, .grant_pkt,
    .next_seq, .replay_vld, .replay_seq, .replay_chan, .replay_pkt, .credit_ok,
    .asm_take, .new_start, .new_pkt, .new_chan, .replay_start,
    .frm_data, .frm_kchr, .frm_last, .frm_vld, .frm_rdy, .reg_sfrm
  );

endmodule

`default_nettype wire

// ==== hss_frm_pkg.sv ====
// hss frame package: sequence number, ack kind, assembler states and frame word layout
`default_nettype none

`include "hss_mux_config.svh"

package hss_frm_pkg;

  // ------------------------------------------------------------
  // sequence and acknowledge
  // ------------------------------------------------------------
  // wraps modulo 2**HSS_SEQ_BITS
  typedef logic [`HSS_SEQ_BITS-1:0] hss_seq_t;

  // kind of remote answer
  typedef enum logic {
    HSS_ACK = 1'b0,
    HSS_NAK = 1'b1
  } hss_ack_e;

  // ------------------------------------------------------------
  // frame assembler FSM
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    ASM_IDLE = 2'd0,
    ASM_HDR  = 2'd1,
    ASM_KEY  = 2'd2,
    ASM_PLD  = 2'd3
  } hss_asm_state_e;

  // ------------------------------------------------------------
  // frame words
  // ------------------------------------------------------------
  typedef logic [31:0] hss_frm_word_t;
  // one k-flag per byte
  typedef logic [3:0]  hss_kbits_t;

  // header word byte positions
  localparam int HSS_FRM_KCHR_LSB = 0;
  localparam int HSS_FRM_HDR_LSB  = 8;
  localparam int HSS_FRM_CHAN_LSB = 16;
  localparam int HSS_FRM_SEQ_LSB  = 24;

endpackage

`default_nettype wire

// ==== hss_mux_config.svh ====
// hss frame tx configuration: channel count, sequence and window sizes, link codes
`ifndef HSS_MUX_CONFIG_SVH
`define HSS_MUX_CONFIG_SVH

// ------------------------------------------------------------
// packet side
// ------------------------------------------------------------
// number of packet channels feeding the mux
`define HSS_NUM_CHANS 8

// ------------------------------------------------------------
// frame and flow control
// ------------------------------------------------------------
// sequence number width, wraps modulo 16
`define HSS_SEQ_BITS 4
// max frames outstanding in retransmit buffer
`define HSS_WINDOW 8
// ack/nak colour width
`define HSS_CLR_BITS 1

// ------------------------------------------------------------
// link codes
// ------------------------------------------------------------
// k-code carried in byte 0 of every frame header word
`define HSS_KCHAR 8'hBC
// k-flag pattern of a header word, byte 0 only
`define HSS_DATA_KBITS 4'b0001

`endif

// ==== hss_pkt_arbiter.sv ====
// hss packet arbiter: round-robin channel pick, masked by remote flow control
`default_nettype none
`timescale 1ns/100ps

`include "hss_mux_config.svh"

module hss_pkt_arbiter
  import hss_pkt_pkg::*;
(
  input  wire                             tbr_clk,
  input  wire                             tbr_rst,

  // packet channels, packed by channel
  input  wire hss_pkt_t [`HSS_NUM_CHANS-1:0] pkt_data,
  input  wire       [`HSS_NUM_CHANS-1:0]  pkt_vld,
  output logic      [`HSS_NUM_CHANS-1:0]  pkt_rdy,

  // remote flow control, low bit masks channel
  input  wire       [`HSS_NUM_CHANS-1:0]  cfc_rem,

  // assembler request and same-cycle grant
  input  wire                             asm_take,
  output logic                            grant_vld,
  output hss_chan_t                       grant_chan,
  output hss_pkt_t                        grant_pkt
);

  // ------------------------------------------------------------
  // channel search
  // ------------------------------------------------------------
  logic [`HSS_NUM_CHANS-1:0] elig;
  hss_chan_t                 last_grant;
  hss_chan_t                 scan;
  hss_chan_t                 pick;
  logic                      pick_vld;

  // valid and permitted by remote end
  assign elig = pkt_vld & cfc_rem;

  // scan downward in distance so the nearest channel
  // after last_grant is the one that sticks
  always_comb
  begin
    pick     = last_grant;
    pick_vld = 1'b0;
    scan     = last_grant;
    for (int i = `HSS_NUM_CHANS; i >= 1; i--)
    begin
      // wraps through chan width
      scan = hss_chan_t'(last_grant + i);
      if (elig[scan])
      begin
        pick     = scan;
        pick_vld = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // grant and ready strobe
  // ------------------------------------------------------------
  assign grant_vld  = asm_take && pick_vld;
  assign grant_chan = pick;
  assign grant_pkt  = pkt_data[pick];

  // one-hot, only in the take cycle
  always_comb
  begin
    pkt_rdy = '0;
    if (grant_vld)
      pkt_rdy[pick] = 1'b1;
  end

  // last-granted, starts at top so channel 0 goes first
  always_ff @(posedge tbr_clk or posedge tbr_rst)
    if (tbr_rst)
      last_grant <= hss_chan_t'(`HSS_NUM_CHANS - 1);
    else if (grant_vld)
      last_grant <= pick;

endmodule

`default_nettype wire

// ==== hss_pkt_pkg.sv ====
// hss packet package: channel index, packet header fields and packet word type
`default_nettype none

`include "hss_mux_config.svh"

package hss_pkt_pkg;

  // ------------------------------------------------------------
  // channel index
  // ------------------------------------------------------------
  typedef logic [$clog2(`HSS_NUM_CHANS)-1:0] hss_chan_t;

  // ------------------------------------------------------------
  // packet layout
  // ------------------------------------------------------------
  // header byte at the bottom, then key, payload on top
  localparam int HSS_PKT_HDR_LSB = 0;
  localparam int HSS_PKT_KEY_LSB = 8;
  localparam int HSS_PKT_PLD_LSB = 40;
  localparam int HSS_PKT_BITS    = 72;

  typedef logic [HSS_PKT_BITS-1:0] hss_pkt_t;

  // header byte
  // bit 0 parity, passed through unchecked
  // bit 1 payload present
  typedef logic [7:0] hss_hdr_t;

  localparam int HSS_HDR_PLD_BIT = 1;

endpackage

`default_nettype wire

// ==== hss_retx_buffer.sv ====
// hss retransmit buffer: stores sent packets by sequence, handles ack/nak, colour and credit
`default_nettype none
`timescale 1ns/100ps

`include "hss_mux_config.svh"

module hss_retx_buffer
  import hss_pkt_pkg::*;
  import hss_frm_pkg::*;
(
  input  wire                           tbr_clk,
  input  wire                           tbr_rst,

  // new frame started by assembler
  input  wire                           new_start,
  input  wire hss_pkt_t                 new_pkt,
  input  wire hss_chan_t                new_chan,
  // replayed frame started by assembler
  input  wire                           replay_start,

  // remote ack/nak strobe
  input  wire hss_ack_e                 ack_type,
  input  wire [`HSS_CLR_BITS-1:0]       ack_colour,
  input  wire hss_seq_t                 ack_seq,
  input  wire                           ack_vld,

  output hss_seq_t                      next_seq,
  output logic                          replay_vld,
  output hss_seq_t                      replay_seq,
  output hss_chan_t                     replay_chan,
  output hss_pkt_t                      replay_pkt,
  output logic                          credit_ok,

  // out-of-credit report
  output logic                          ooc_vld,
  output logic [`HSS_CLR_BITS-1:0]      ooc_colour,

  // status
  output logic                          reg_rack,
  output logic                          reg_rnak,
  output logic                          reg_looc,
  output logic                          reg_empt,
  output logic                          reg_full
);

  localparam int IDX_BITS = $clog2(`HSS_WINDOW);

  // ------------------------------------------------------------
  // storage, indexed by low sequence bits
  // ------------------------------------------------------------
  hss_pkt_t                pkt_mem  [`HSS_WINDOW];
  hss_chan_t               chan_mem [`HSS_WINDOW];

  hss_seq_t                base_seq;
  hss_seq_t                rp_seq;
  logic [`HSS_CLR_BITS-1:0] colour;
  logic                    full;
  logic                    full_q;

  // offsets from base, all modulo 16
  hss_seq_t                in_flight;
  hss_seq_t                ack_ofs;
  hss_seq_t                rp_ofs;
  logic                    ack_ok;
  logic                    take_ack;
  logic                    take_nak;

  always_ff @(posedge tbr_clk)
    if (new_start)
    begin
      pkt_mem[next_seq[IDX_BITS-1:0]]  <= new_pkt;
      chan_mem[next_seq[IDX_BITS-1:0]] <= new_chan;
    end

  // ------------------------------------------------------------
  // ack/nak filter
  // ------------------------------------------------------------
  assign in_flight = next_seq - base_seq;
  assign ack_ofs   = ack_seq - base_seq;
  assign rp_ofs    = rp_seq - base_seq;

  // current colour and base..next inclusive, else stale
  assign ack_ok   = ack_vld && (ack_colour == colour) && (ack_ofs <= in_flight);
  assign take_ack = ack_ok && (ack_type == HSS_ACK);
  assign take_nak = ack_ok && (ack_type == HSS_NAK);

  // ------------------------------------------------------------
  // pointers, colour and pulses
  // ------------------------------------------------------------
  always_ff @(posedge tbr_clk or posedge tbr_rst)
    if (tbr_rst)
    begin
      next_seq <= '0;
      base_seq <= '0;
      rp_seq   <= '0;
      colour   <= '0;
      full_q   <= 1'b0;
      reg_rack <= 1'b0;
      reg_rnak <= 1'b0;
    end
    else
    begin
      if (new_start)
        next_seq <= next_seq + hss_seq_t'(1);
      // ack releases all frames before ack_seq
      if (take_ack)
        base_seq <= ack_seq;
      // nak rewinds, ack past replay point skips acked frames
      if (take_nak)
        rp_seq <= ack_seq;
      else if (take_ack && (rp_ofs < ack_ofs))
        rp_seq <= ack_seq;
      else if (replay_start || new_start)
        rp_seq <= rp_seq + hss_seq_t'(1);
      if (take_nak)
        colour <= ~colour;
      full_q   <= full;
      reg_rack <= take_ack;
      reg_rnak <= take_nak;
    end

  // ------------------------------------------------------------
  // replay and credit status
  // ------------------------------------------------------------
  assign replay_vld  = (rp_seq != next_seq);
  assign replay_seq  = rp_seq;
  assign replay_pkt  = pkt_mem[rp_seq[IDX_BITS-1:0]];
  assign replay_chan = chan_mem[rp_seq[IDX_BITS-1:0]];

  assign full      = (in_flight == hss_seq_t'(`HSS_WINDOW));
  assign credit_ok = !full;
  assign reg_full  = full;
  assign reg_empt  = (in_flight == '0);
  // rising edge of full only
  assign reg_looc  = full && !full_q;

  // hold back ooc while a replay still has to go out
  assign ooc_vld    = full && !replay_vld;
  assign ooc_colour = colour;

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
hss_pkt_pkg.sv
hss_frm_pkg.sv
hss_pkt_arbiter.sv
hss_retx_buffer.sv
hss_frame_assembler.sv
hss_frame_tx_top.sv
hss_frame_tx_tb.sv
